// ==== Bender.yml ====
package:
  name: core

sources:
  - include_dirs:
      - include
    files:
      - hw/core_pkg.sv
      - hw/inst_decode.sv
      - hw/reg_file.sv
      - hw/exec_unit.sv
      - hw/uart_tx_master.sv
      - hw/core_top.sv
  - target: simulation
    include_dirs:
      - include
    files:
      - sim/tb_mem_uart.sv
      - sim/tb_core.sv

// ==== files.f ====
+incdir+include
hw/core_pkg.sv
hw/inst_decode.sv
hw/reg_file.sv
hw/exec_unit.sv
hw/uart_tx_master.sv
hw/core_top.sv
sim/tb_mem_uart.sv
sim/tb_core.sv

// ==== hw/core_pkg.sv ====
`default_nettype none

package core_pkg;

    // one instruction word, two field layouts
    typedef union packed {
        struct packed {
            logic [6:0] funct7;
            logic [4:0] rs2;
            logic [4:0] rs1;
            logic [2:0] funct3;
            logic [4:0] rd;
            logic [6:0] opcode;
        } r;
        struct packed {
            logic [11:0] imm12;
            logic [4:0]  rs1;
            logic [2:0]  funct3;
            logic [4:0]  rd;
            logic [6:0]  opcode;
        } i;
    } instr_u;

endpackage

`default_nettype wire

// ==== hw/core_top.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "core_consts.svh"

module core_top (
    input  wire                     clk,
    input  wire                     rst,
    output logic [`CORE_IMEM_AW-1:0] imem_addr,
    input  wire core_pkg::instr_u   imem_data,
    output logic                    dmem_we,
    output logic [`CORE_DMEM_AW-1:0] dmem_addr,
    output logic [`CORE_XLEN-1:0]   dmem_wdata,
    input  wire  [`CORE_XLEN-1:0]   dmem_rdata,
    output logic [31:0]             araddr,
    output logic                    arvalid,
    input  wire                     arready,
    input  wire  [31:0]             rdata,
    input  wire  [1:0]              rresp,
    input  wire                     rvalid,
    output logic                    rready,
    output logic [31:0]             awaddr,
    output logic                    awvalid,
    input  wire                     awready,
    output logic [31:0]             wdata,
    output logic [3:0]              wstrb,
    output logic                    wvalid,
    input  wire                     wready,
    input  wire  [1:0]              bresp,
    input  wire                     bvalid,
    output logic                    bready,
    output logic                    halted
);

    import core_pkg::*;

    localparam logic [2:0] PH_FETCH = 3'd0;
    localparam logic [2:0] PH_OPER  = 3'd1;
    localparam logic [2:0] PH_EXEC  = 3'd2;
    localparam logic [2:0] PH_COMP  = 3'd3;
    localparam logic [2:0] PH_HALT  = 3'd4;

    logic [2:0] phase;
    logic [`CORE_XLEN-1:0] pc;
    logic [`CORE_XLEN-1:0] npc_q;
    logic [`CORE_XLEN-1:0] op1;
    logic [`CORE_XLEN-1:0] op2;
    logic [`CORE_XLEN-1:0] result_q;
    logic [1:0] exec_cnt;
    logic exec_first;
    logic wb_pend;

    instr_u instr;
    logic [31:0] imm_i, imm_s, imm_u, imm_b;
    logic [4:0] shamt;
    logic [1:0] exec_cycles;
    logic [`CORE_XLEN-1:0] rd1, rd2;
    logic [31:0] result, next_pc;
    logic [17:0] mem_addr;
    logic store, writes_rd;
    logic is_out, last, start, done, wb_en;

    assign is_out = instr.r.opcode == `CORE_OP_INOUT && instr.r.funct3 == `CORE_F3_OUT;
    assign last = is_out ? done : exec_cnt == 2'd1;
    assign start = phase == PH_EXEC && exec_first && is_out;
    assign wb_en = phase == PH_FETCH && wb_pend; // rd still from previous instr
    assign imem_addr = npc_q[`CORE_IMEM_AW+1:2]; // sampled at end of completion
    assign halted = phase == PH_HALT;

    always_ff @(posedge clk) begin
        if (!rst) begin
            phase <= PH_FETCH;
            pc <= '0;
            npc_q <= '0;
            exec_cnt <= 2'd0;
            exec_first <= 1'b0;
            wb_pend <= 1'b0;
            dmem_we <= 1'b0;
        end else begin
            dmem_we <= 1'b0;
            case (phase)
                PH_FETCH: begin
                    wb_pend <= 1'b0;
                    phase <= PH_OPER;
                end
                PH_OPER: begin
                    exec_cnt <= exec_cycles;
                    exec_first <= 1'b1;
                    phase <= PH_EXEC;
                end
                PH_EXEC: begin
                    exec_first <= 1'b0;
                    exec_cnt <= exec_cnt - 2'd1;
                    npc_q <= next_pc;
                    if (last) begin
                        dmem_we <= store;
                        wb_pend <= writes_rd;
                        phase <= PH_COMP;
                    end
                end
                PH_COMP: begin
                    pc <= npc_q;
                    phase <= (npc_q == pc) ? PH_HALT : PH_FETCH; // jump to self
                end
                default: phase <= PH_HALT;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (phase == PH_OPER) begin
            op1 <= rd1;
            op2 <= rd2;
        end
        if (phase == PH_EXEC) begin
            result_q <= result;
            dmem_addr <= mem_addr;
            dmem_wdata <= op2;
        end
        if (phase == PH_COMP && instr.r.opcode == `CORE_OP_LOAD) begin
            result_q <= dmem_rdata;
        end
    end

    inst_decode u_decode (
        .clk         (clk),
        .rst         (rst),
        .load        (phase == PH_FETCH),
        .imem_data   (imem_data),
        .instr       (instr),
        .imm_i       (imm_i),
        .imm_s       (imm_s),
        .imm_u       (imm_u),
        .imm_b       (imm_b),
        .imm_j       (),
        .shamt       (shamt),
        .exec_cycles (exec_cycles)
    );

    reg_file u_regs (
        .clk   (clk),
        .rst   (rst),
        .rs1   (instr.r.rs1),
        .rs2   (instr.r.rs2),
        .wa    (instr.r.rd),
        .wb_en (wb_en),
        .wd    (result_q),
        .rd1   (rd1),
        .rd2   (rd2)
    );

    exec_unit u_exec (
        .instr     (instr),
        .pc        (pc),
        .op1       (op1),
        .op2       (op2),
        .imm_i     (imm_i),
        .imm_s     (imm_s),
        .imm_u     (imm_u),
        .imm_b     (imm_b),
        .shamt     (shamt),
        .result    (result),
        .next_pc   (next_pc),
        .mem_addr  (mem_addr),
        .store     (store),
        .writes_rd (writes_rd)
    );

    uart_tx_master u_uart (
        .clk     (clk),
        .rst     (rst),
        .start   (start),
        .tx_data (op1[7:0]),
        .araddr  (araddr),
        .arvalid (arvalid),
        .arready (arready),
        .rdata   (rdata),
        .rresp   (rresp),
        .rvalid  (rvalid),
        .rready  (rready),
        .awaddr  (awaddr),
        .awvalid (awvalid),
        .awready (awready),
        .wdata   (wdata),
        .wstrb   (wstrb),
        .wvalid  (wvalid),
        .wready  (wready),
        .bresp   (bresp),
        .bvalid  (bvalid),
        .bready  (bready),
        .done    (done)
    );

endmodule

`default_nettype wire

// ==== hw/exec_unit.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "core_consts.svh"

module exec_unit (
    input  wire core_pkg::instr_u  instr,
    input  wire [31:0]  pc,
    input  wire [31:0]  op1,
    input  wire [31:0]  op2,
    input  wire [31:0]  imm_i,
    input  wire [31:0]  imm_s,
    input  wire [31:0]  imm_u,
    input  wire [31:0]  imm_b,
    input  wire [4:0]   shamt,
    output logic [31:0] result,
    output logic [31:0] next_pc,
    output logic [17:0] mem_addr,
    output logic        store,
    output logic        writes_rd
);

    logic signed [`CORE_XLEN-1:0] a;
    logic signed [`CORE_XLEN-1:0] b;
    logic [`CORE_XLEN-1:0] seq_pc;
    logic [`CORE_XLEN-1:0] ls_addr;
    logic taken;

    assign a = op1;
    assign b = op2;
    assign seq_pc = pc + 32'd4;

    assign store = instr.r.opcode == `CORE_OP_STORE;
    assign ls_addr = op1 + (store ? imm_s : imm_i);
    assign mem_addr = ls_addr[19:2]; // word address

    always_comb begin
        case (instr.r.funct3)
            `CORE_F3_BEQ: taken = a == b;
            `CORE_F3_BNE: taken = a != b;
            `CORE_F3_BLT: taken = a < b; // signed
            `CORE_F3_BGE: taken = a >= b;
            default:      taken = 1'b0;
        endcase
    end

    always_comb begin
        result = op1;
        next_pc = seq_pc;
        writes_rd = 1'b0;
        case (instr.r.opcode)
            `CORE_OP_IMM: begin
                writes_rd = 1'b1;
                case (instr.r.funct3)
                    `CORE_F3_ADD: result = op1 + imm_i;
                    `CORE_F3_SLL: result = op1 << shamt;
                    `CORE_F3_XOR: result = op1 ^ imm_i;
                    `CORE_F3_SRA: result = a >>> shamt;
                    `CORE_F3_AND: result = op1 & imm_i;
                    default:      result = op1;
                endcase
            end
            `CORE_OP_OP: begin
                writes_rd = 1'b1;
                case (instr.r.funct3)
                    `CORE_F3_ADD: begin
                        result = (instr.r.funct7 == `CORE_F7_SUB) ? op1 - op2 : op1 + op2;
                    end
                    `CORE_F3_XOR: result = op1 ^ op2;
                    default:      result = op1;
                endcase
            end
            `CORE_OP_LUI: begin
                writes_rd = 1'b1;
                result = imm_u;
            end
            `CORE_OP_AUIPC: begin
                writes_rd = 1'b1;
                result = pc + imm_u;
            end
            `CORE_OP_JALR: begin
                writes_rd = 1'b1;
                result = seq_pc; // link
                next_pc = op1 + imm_i;
            end
            `CORE_OP_BRANCH: begin
                if (taken) begin
                    next_pc = pc + imm_b;
                end
            end
            `CORE_OP_LOAD: writes_rd = 1'b1; // data arrives at completion
            default: writes_rd = 1'b0;
        endcase
    end

endmodule

`default_nettype wire

// ==== hw/inst_decode.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "core_consts.svh"

module inst_decode (
    input  wire              clk,
    input  wire              rst,
    input  wire              load,
    input  wire core_pkg::instr_u imem_data,
    output core_pkg::instr_u instr,
    output logic [31:0]      imm_i,
    output logic [31:0]      imm_s,
    output logic [31:0]      imm_u,
    output logic [31:0]      imm_b,
    output logic [31:0]      imm_j,
    output logic [4:0]       shamt,
    output logic [1:0]       exec_cycles
);

    logic [31:0] w;

    always_ff @(posedge clk) begin
        if (!rst) begin
            instr <= '0;
        end else if (load) begin
            instr <= imem_data; // latched at end of fetch
        end
    end

    assign w = instr;

    assign imm_i = {{20{instr.i.imm12[11]}}, instr.i.imm12};
    assign imm_s = {{20{w[31]}}, instr.r.funct7, instr.r.rd};
    assign imm_u = {w[31:12], 12'b0};
    assign imm_b = {{20{w[31]}}, w[7], w[30:25], w[11:8], 1'b0};
    assign imm_j = {{12{w[31]}}, w[19:12], w[20], w[30:21], 1'b0};
    assign shamt = instr.r.rs2;

    // load needs an extra cycle for the memory read
    assign exec_cycles = (instr.r.opcode == `CORE_OP_LOAD) ? 2'd2 : 2'd1;

endmodule

`default_nettype wire

// ==== hw/reg_file.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "core_consts.svh"

module reg_file (
    input  wire                   clk,
    input  wire                   rst,
    input  wire [4:0]             rs1,
    input  wire [4:0]             rs2,
    input  wire [4:0]             wa,
    input  wire                   wb_en,
    input  wire [`CORE_XLEN-1:0]  wd,
    output logic [`CORE_XLEN-1:0] rd1,
    output logic [`CORE_XLEN-1:0] rd2
);

    logic signed [`CORE_XLEN-1:0] regs [32];

    always_ff @(posedge clk) begin
        if (!rst) begin
            regs[2] <= `CORE_STACK_INIT; // sp
        end else if (wb_en && wa != 5'd0) begin
            regs[wa] <= wd;
        end
    end

    assign rd1 = (rs1 == 5'd0) ? '0 : regs[rs1]; // x0 never written
    assign rd2 = (rs2 == 5'd0) ? '0 : regs[rs2];

endmodule

`default_nettype wire

// ==== hw/uart_tx_master.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "core_consts.svh"

module uart_tx_master (
    input  wire         clk,
    input  wire         rst,
    input  wire         start,
    input  wire  [7:0]  tx_data,
    output logic [31:0] araddr,
    output logic        arvalid,
    input  wire         arready,
    input  wire  [31:0] rdata,
    input  wire  [1:0]  rresp,
    input  wire         rvalid,
    output logic        rready,
    output logic [31:0] awaddr,
    output logic        awvalid,
    input  wire         awready,
    output logic [31:0] wdata,
    output logic [3:0]  wstrb,
    output logic        wvalid,
    input  wire         wready,
    input  wire  [1:0]  bresp,
    input  wire         bvalid,
    output logic        bready,
    output logic        done
);

    localparam logic [2:0] ST_IDLE = 3'd0;
    localparam logic [2:0] ST_AR   = 3'd1;
    localparam logic [2:0] ST_R    = 3'd2;
    localparam logic [2:0] ST_W    = 3'd3;
    localparam logic [2:0] ST_B    = 3'd4;

    logic [2:0] state;
    logic stat_busy;

    assign araddr = `UART_STAT_ADDR;
    assign awaddr = `UART_TX_ADDR;
    assign wstrb = 4'b0001;

    // an error response counts as full, so the status is read again
    assign stat_busy = rdata[`UART_STAT_TX_FULL] || rresp != 2'b00;
    assign done = state == ST_B && bvalid && bresp == 2'b00;

    always_ff @(posedge clk) begin
        if (!rst) begin
            state <= ST_IDLE;
            arvalid <= 1'b0;
            rready <= 1'b0;
            awvalid <= 1'b0;
            wvalid <= 1'b0;
            bready <= 1'b0;
        end else begin
            case (state)
                ST_IDLE: if (start) begin
                    arvalid <= 1'b1;
                    state <= ST_AR;
                end
                ST_AR: if (arready) begin
                    arvalid <= 1'b0;
                    rready <= 1'b1;
                    state <= ST_R;
                end
                ST_R: if (rvalid) begin
                    rready <= 1'b0;
                    if (stat_busy) begin
                        arvalid <= 1'b1; // poll again
                        state <= ST_AR;
                    end else begin
                        awvalid <= 1'b1;
                        wvalid <= 1'b1;
                        state <= ST_W;
                    end
                end
                ST_W: begin
                    if (awready) awvalid <= 1'b0; // each channel drops on its own
                    if (wready) wvalid <= 1'b0;
                    if ((!awvalid || awready) && (!wvalid || wready)) begin
                        bready <= 1'b1;
                        state <= ST_B;
                    end
                end
                ST_B: if (bvalid) begin
                    bready <= 1'b0;
                    if (bresp != 2'b00) begin
                        awvalid <= 1'b1; // retry rejected write
                        wvalid <= 1'b1;
                        state <= ST_W;
                    end else begin
                        state <= ST_IDLE;
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == ST_IDLE && start) begin
            wdata <= {24'b0, tx_data};
        end
    end

endmodule

`default_nettype wire

// ==== include/core_consts.svh ====
`ifndef CORE_CONSTS_SVH
`define CORE_CONSTS_SVH

`define CORE_XLEN        32
`define CORE_IMEM_AW     15 // word address
`define CORE_DMEM_AW     18 // word address

// stack starts at the top of data memory
`define CORE_STACK_INIT  (32'd1 << (`CORE_DMEM_AW + 2))

`define CORE_OP_IMM      7'b0010011
`define CORE_OP_OP       7'b0110011
`define CORE_OP_LUI      7'b0110111
`define CORE_OP_AUIPC    7'b0010111
`define CORE_OP_JALR     7'b1100111
`define CORE_OP_BRANCH   7'b1100011
`define CORE_OP_LOAD     7'b0000011
`define CORE_OP_STORE    7'b0100011
`define CORE_OP_INOUT    7'b1111111

`define CORE_F3_ADD      3'b000
`define CORE_F3_SLL      3'b001
`define CORE_F3_XOR      3'b100
`define CORE_F3_SRA      3'b101
`define CORE_F3_AND      3'b111
`define CORE_F3_BEQ      3'b000
`define CORE_F3_BNE      3'b001
`define CORE_F3_BLT      3'b100
`define CORE_F3_BGE      3'b101
`define CORE_F3_OUT      3'b000
`define CORE_F7_SUB      7'b0100000

`define UART_TX_ADDR     32'd4
`define UART_STAT_ADDR   32'd8
`define UART_STAT_TX_FULL 3

`endif

// ==== sim/tb_core.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "core_consts.svh"

module tb_core;

    logic clk, rst;
    logic [7:0] rnd;
    logic [31:0] lcg_state;
    logic [14:0] imem_addr;
    logic [31:0] imem_data, dmem_wdata, dmem_rdata;
    logic [17:0] dmem_addr;
    logic dmem_we, halted;
    logic [31:0] araddr, rdata, awaddr, wdata, tx_addr;
    logic [1:0] rresp, bresp;
    logic [3:0] wstrb, tx_strb;
    logic arvalid, arready, rvalid, rready, awvalid, awready, wvalid, wready, bvalid, bready;
    logic tx_event;
    logic [7:0] tx_byte;
    logic [31:0] prog [$];
    logic [17:0] exp_addr [$];
    logic [31:0] exp_data [$];
    logic [7:0] exp_tx [$];
    logic checking;
    int n_instr;
    longint wd_limit;

    core_top uut (.*);
    tb_mem_uart mem (.*);

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state;
    endfunction

    function automatic logic [31:0] enc_i(logic [6:0] op, logic [4:0] rd, logic [2:0] f3,
                                          logic [4:0] rs1, logic [11:0] imm);
        return {imm, rs1, f3, rd, op};
    endfunction

    function automatic logic [31:0] enc_r(logic [6:0] f7, logic [4:0] rs2, logic [4:0] rs1,
                                          logic [2:0] f3, logic [4:0] rd, logic [6:0] op);
        return {f7, rs2, rs1, f3, rd, op};
    endfunction

    function automatic logic [31:0] enc_s(logic [4:0] rs2, logic [4:0] rs1, logic [11:0] imm);
        return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], `CORE_OP_STORE};
    endfunction

    function automatic logic [31:0] enc_b(logic [2:0] f3, logic [4:0] rs1, logic [4:0] rs2,
                                          logic [12:0] off);
        return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], `CORE_OP_BRANCH};
    endfunction

    task automatic build_program();
        logic [31:0] r;
        logic [4:0] rd, rs1, rs2;
        logic [2:0] bf [4];
        bf = '{`CORE_F3_BEQ, `CORE_F3_BNE, `CORE_F3_BLT, `CORE_F3_BGE};
        for (int k = 5; k <= 12; k++) prog.push_back(enc_i(`CORE_OP_IMM, k, 0, 0, lcg_next()));
        for (int k = 0; k < 24; k++) begin
            r = lcg_next();
            rd = 5 + r[18:16];
            rs1 = 5 + r[21:19];
            rs2 = 5 + r[24:22];
            case (r[30:27] % 10)
                0: prog.push_back(enc_i(`CORE_OP_IMM, rd, `CORE_F3_ADD, rs1, r[11:0]));
                1: prog.push_back(enc_r(0, r[4:0], rs1, `CORE_F3_SLL, rd, `CORE_OP_IMM));
                2: prog.push_back(enc_i(`CORE_OP_IMM, rd, `CORE_F3_XOR, rs1, r[11:0]));
                3: prog.push_back(enc_r(`CORE_F7_SUB, r[4:0], rs1, `CORE_F3_SRA, rd, `CORE_OP_IMM));
                4: prog.push_back(enc_i(`CORE_OP_IMM, rd, `CORE_F3_AND, rs1, r[11:0]));
                5: prog.push_back(enc_r(0, rs2, rs1, `CORE_F3_ADD, rd, `CORE_OP_OP));
                6: prog.push_back(enc_r(`CORE_F7_SUB, rs2, rs1, `CORE_F3_ADD, rd, `CORE_OP_OP));
                7: prog.push_back(enc_r(0, rs2, rs1, `CORE_F3_XOR, rd, `CORE_OP_OP));
                8: prog.push_back({r[19:0], rd, `CORE_OP_LUI});
                default: prog.push_back({r[19:0], rd, `CORE_OP_AUIPC});
            endcase
        end
        for (int k = 5; k <= 12; k++) prog.push_back(enc_s(k, 0, 256 + 4 * k));
        // reload and store back elsewhere
        prog.push_back(enc_i(`CORE_OP_LOAD, 13, 3'b010, 0, 276));
        prog.push_back(enc_s(13, 0, 400));
        prog.push_back(enc_s(6, 2, -4)); // top of stack
        prog.push_back(enc_i(`CORE_OP_LOAD, 14, 3'b010, 2, -4));
        prog.push_back(enc_s(14, 0, 404));
        for (int k = 0; k < 16; k++) begin
            r = lcg_next();
            prog.push_back(enc_i(`CORE_OP_IMM, 15, 0, 0, {{9{r[2]}}, r[2:0]}));
            prog.push_back(enc_i(`CORE_OP_IMM, 16, 0, 0, {{9{r[5]}}, r[5:3]}));
            prog.push_back(enc_b(bf[r[7:6]], 15, 16, 8));
            prog.push_back(enc_s(15, 0, 600 + 4 * k)); // skipped when taken
        end
        prog.push_back({20'b0, 5'd17, `CORE_OP_AUIPC});
        prog.push_back(enc_i(`CORE_OP_JALR, 18, 0, 17, 12));
        prog.push_back(enc_s(5, 0, 800));
        prog.push_back(enc_s(18, 0, 804));
        for (int k = 0; k < 6; k++) begin
            prog.push_back(enc_i(`CORE_OP_IMM, 19, 0, 0, lcg_next()));
            prog.push_back(enc_i(`CORE_OP_INOUT, 0, `CORE_F3_OUT, 19, 0));
        end
        prog.push_back(enc_i(`CORE_OP_INOUT, 0, 3'b001, 19, 0)); // nonzero funct3 does nothing
        prog.push_back(enc_b(`CORE_F3_BEQ, 0, 0, 0));
    endtask

    // ISA-level interpreter filling the expected queues
    function automatic int run_reference();
        logic [31:0] x [32];
        logic [31:0] dm [int];
        logic [31:0] w, pc, npc, v, u, res, a, ii, is, ib, iu;
        logic wr, take;
        int steps;
        foreach (x[i]) x[i] = 0;
        x[2] = `CORE_STACK_INIT;
        pc = 0;
        for (steps = 1; steps < 5000; steps++) begin
            w = prog[pc >> 2];
            npc = pc + 4;
            v = x[w[19:15]];
            u = x[w[24:20]];
            ii = {{20{w[31]}}, w[31:20]};
            is = {{20{w[31]}}, w[31:25], w[11:7]};
            ib = {{20{w[31]}}, w[7], w[30:25], w[11:8], 1'b0};
            iu = {w[31:12], 12'b0};
            wr = 1;
            res = 0;
            case (w[6:0])
                `CORE_OP_IMM: case (w[14:12])
                    `CORE_F3_ADD: res = v + ii;
                    `CORE_F3_SLL: res = v << w[24:20];
                    `CORE_F3_XOR: res = v ^ ii;
                    `CORE_F3_SRA: res = $signed(v) >>> w[24:20];
                    default: res = v & ii;
                endcase
                `CORE_OP_OP: res = (w[14:12] == `CORE_F3_XOR) ? v ^ u : (w[30] ? v - u : v + u);
                `CORE_OP_LUI: res = iu;
                `CORE_OP_AUIPC: res = pc + iu;
                `CORE_OP_JALR: begin
                    res = pc + 4;
                    npc = v + ii;
                end
                `CORE_OP_LOAD: begin
                    a = v + ii;
                    res = dm.exists(a[19:2]) ? dm[a[19:2]] : 0;
                end
                default: begin
                    wr = 0;
                    take = 0;
                    case (w[14:12])
                        `CORE_F3_BEQ: take = v == u;
                        `CORE_F3_BNE: take = v != u;
                        `CORE_F3_BLT: take = $signed(v) < $signed(u);
                        `CORE_F3_BGE: take = $signed(v) >= $signed(u);
                        default: take = 0;
                    endcase
                    if (w[6:0] == `CORE_OP_BRANCH && take) npc = pc + ib;
                    if (w[6:0] == `CORE_OP_STORE) begin
                        a = v + is;
                        dm[a[19:2]] = u;
                        exp_addr.push_back(a[19:2]);
                        exp_data.push_back(u);
                    end
                    if (w[6:0] == `CORE_OP_INOUT && w[14:12] == `CORE_F3_OUT) begin
                        exp_tx.push_back(v[7:0]);
                    end
                end
            endcase
            if (wr && w[11:7] != 0) x[w[11:7]] = res;
            if (npc == pc) return steps;
            pc = npc;
        end
        return steps;
    endfunction

    task automatic fail_run(string msg);
        $display("%s", msg);
        $display("SIMULATION FAILED");
        $fatal(1);
    endtask

    initial begin
        clk = 0;
        forever #10 clk = ~clk;
    end

    initial begin
        rst = 0;
        rnd = 0;
        checking = 0;
        lcg_state = 32'd65278;
        build_program();
        foreach (prog[i]) mem.imem[i] = prog[i];
        n_instr = run_reference();
        wd_limit = 64'd20 * (10 + 200 + 2 * (n_instr * 5 + exp_tx.size() * 300));
        repeat (10) @(negedge clk);
        assert (!dmem_we && !arvalid && !rready && !awvalid && !wvalid && !bready
                && !halted && imem_addr == 0)
            else fail_run($sformatf("mismatch at %0t: outputs not idle in reset", $time));
        @(posedge clk);
        #1 rst = 1;
        checking = 1;
        wait (halted);
        repeat (200) @(negedge clk); // nothing may follow the halt
        if (exp_addr.size() != 0 || exp_tx.size() != 0) begin
            fail_run($sformatf("core halted with %0d stores and %0d bytes still expected",
                               exp_addr.size(), exp_tx.size()));
        end else begin
            $display("SIMULATION PASSED");
            $finish;
        end
    end

    initial begin
        forever begin
            @(posedge clk);
            #1 rnd = lcg_next() >> 16;
        end
    end

    always @(negedge clk) begin
        if (checking && arvalid) begin
            assert (araddr == `UART_STAT_ADDR)
                else fail_run($sformatf("mismatch at %0t: status read address %h, expected %h",
                                        $time, araddr, `UART_STAT_ADDR));
        end
        if (checking && dmem_we) begin
            assert (exp_addr.size() > 0)
                else fail_run("store seen with no store left in the program");
            assert (dmem_addr == exp_addr[0] && dmem_wdata == exp_data[0])
                else fail_run($sformatf("mismatch at %0t: store %h <= %h, expected %h <= %h",
                                        $time, dmem_addr, dmem_wdata, exp_addr[0], exp_data[0]));
            void'(exp_addr.pop_front());
            void'(exp_data.pop_front());
        end
        if (checking && tx_event) begin
            assert (exp_tx.size() > 0) else fail_run("UART byte seen with none left to send");
            assert (tx_byte == exp_tx[0] && tx_addr == `UART_TX_ADDR && tx_strb == 4'b0001)
                else fail_run($sformatf(
                    "mismatch at %0t: uart byte %h addr %h strb %b, expected %h",
                    $time, tx_byte, tx_addr, tx_strb, exp_tx[0]));
            void'(exp_tx.pop_front());
        end
    end

    initial begin
        wait (checking);
        #(wd_limit);
        fail_run("watchdog expired before the core halted");
    end

endmodule

`default_nettype wire

// ==== sim/tb_mem_uart.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_mem_uart (
    input  wire         clk,
    input  wire         rst,
    input  wire  [7:0]  rnd,
    input  wire  [14:0] imem_addr,
    output logic [31:0] imem_data,
    input  wire         dmem_we,
    input  wire  [17:0] dmem_addr,
    input  wire  [31:0] dmem_wdata,
    output logic [31:0] dmem_rdata,
    input  wire         arvalid,
    output logic        arready,
    output logic [31:0] rdata,
    output logic [1:0]  rresp,
    output logic        rvalid,
    input  wire         rready,
    input  wire  [31:0] awaddr,
    input  wire         awvalid,
    output logic        awready,
    input  wire  [31:0] wdata,
    input  wire  [3:0]  wstrb,
    input  wire         wvalid,
    output logic        wready,
    output logic [1:0]  bresp,
    output logic        bvalid,
    input  wire         bready,
    output logic        tx_event,
    output logic [7:0]  tx_byte,
    output logic [31:0] tx_addr,
    output logic [3:0]  tx_strb
);

    logic [31:0] imem [0:32767];
    logic [31:0] dmem [0:262143];
    logic r_pend, aw_got, w_got;

    initial begin
        for (int a = 0; a < 262144; a++) begin
            dmem[a] = a * 32'h9e3779b1; // address hash
        end
    end

    always @(posedge clk) begin
        imem_data <= imem[imem_addr];
        dmem_rdata <= dmem[dmem_addr];
        if (dmem_we) dmem[dmem_addr] <= dmem_wdata;
    end

    assign rresp = 2'b00;
    assign bresp = 2'b00;

    always @(posedge clk) begin
        if (!rst) begin
            arready <= 1'b0;
            rvalid <= 1'b0;
            r_pend <= 1'b0;
            awready <= 1'b0;
            wready <= 1'b0;
            bvalid <= 1'b0;
            aw_got <= 1'b0;
            w_got <= 1'b0;
            tx_event <= 1'b0;
            rdata <= '0;
        end else begin
            tx_event <= 1'b0;
            arready <= arvalid && !arready && !r_pend && !rvalid && rnd[0];
            if (arvalid && arready) begin
                r_pend <= 1'b1;
                rdata <= {28'b0, rnd[6] & rnd[7], 3'b0}; // tx full one time in four
            end
            if (r_pend && rnd[3]) begin
                r_pend <= 1'b0;
                rvalid <= 1'b1;
            end
            if (rvalid && rready) rvalid <= 1'b0;
            awready <= awvalid && !awready && !aw_got && rnd[1];
            wready <= wvalid && !wready && !w_got && rnd[2];
            if (awvalid && awready) begin
                aw_got <= 1'b1;
                tx_addr <= awaddr;
            end
            if (wvalid && wready) begin
                w_got <= 1'b1;
                tx_byte <= wdata[7:0];
                tx_strb <= wstrb;
            end
            if (aw_got && w_got && !bvalid && rnd[4]) begin
                bvalid <= 1'b1;
                aw_got <= 1'b0;
                w_got <= 1'b0;
                tx_event <= 1'b1;
            end
            if (bvalid && bready) bvalid <= 1'b0;
        end
    end

endmodule

`default_nettype wire
